//--- run.sh
#!/bin/sh
# Build and run the TCDM burst subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_tcdm_burst_subsys \
  -f vlog.f \
  -o tb_tcdm_burst_subsys
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build returned an error"
  exit $status
fi

./obj_dir/tb_tcdm_burst_subsys
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run returned an error"
  exit $status
fi

exit 0

//--- tb_clk_gen.sv
// Testbench clock and reset source, 8 ns clock with reset held low for four cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #4 clk_o = ~clk_o;
    end
  end

  // Release lands between clock edges
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

//--- tb_tcdm_burst_subsys.sv
// Testbench for the TCDM burst subsystem with a reference memory and an ID scoreboard
`timescale 1ns/1ps

module tb_tcdm_burst_subsys;
  import tcdm_pkg::*;

  localparam int WaitLimit  = 200;
  localparam int NumReads   = 60;
  localparam int NumBWrites = 6;
  localparam int NumWords   = NumTiles * TileDepth;
  localparam int NumIds     = 1 << MetaIdWidth;

  logic      clk;
  logic      rst_n;
  tcdm_req_t req;
  logic      req_valid;
  logic      req_ready;
  tcdm_rsp_t rsp;
  logic      rsp_valid;
  logic      rsp_ready = 1'b0;

  // Reference memory by word address
  data_t     ref_mem [NumWords];

  // Scoreboard by ID where an ID is outstanding while issued more often than answered
  int        issue_count [NumIds] = '{default: 0};
  int        rsp_count [NumIds] = '{default: 0};
  addr_t     exp_addr [NumIds];
  logic      exp_write [NumIds];
  meta_id_t  next_id;
  int        seed;
  int        ready_seed = 89862;

  logic      seen_accept = 1'b0;
  logic      stall_q = 1'b0;
  tcdm_rsp_t stalled_rsp;
  addr_t     bw_addr [$];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_burst_subsys DUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  function automatic int word_of(input addr_t addr);
    return (int'(addr) >> ByteOffset) % NumWords;
  endfunction

  // Initial contents differ from word to word
  function automatic data_t fill_word(input int w);
    return {16'hA5C3, 2'b00, 7'(w), 7'(~w)};
  endfunction

  function automatic logic ids_free(input meta_id_t base, input int beats);
    meta_id_t slot;
    logic     free;
    free = 1'b1;
    for (int i = 0; i < beats; i++) begin
      slot = base + meta_id_t'(i);
      if (issue_count[slot] != rsp_count[slot]) begin
        free = 1'b0;
      end
    end
    return free;
  endfunction

  function automatic int pending_count();
    int total;
    total = 0;
    for (int i = 0; i < NumIds; i++) begin
      total += issue_count[i] - rsp_count[i];
    end
    return total;
  endfunction

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_wrong_value(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while %s", $time, what);
    end_with_failure();
  endtask

  // Issues one request and books every beat it should return
  task automatic send_req(input addr_t addr, input logic write, input data_t data,
                          input strb_t strb, input logic isburst, input blen_t blen);
    int       beats;
    int       waited;
    int       w;
    meta_id_t slot;
    logic     accepted;
    beats  = (!write && isburst && (blen > blen_t'(1))) ? int'(blen) : 1;
    waited = 0;
    while (!ids_free(next_id, beats)) begin
      @(negedge clk);
      waited++;
      if (waited > WaitLimit) begin
        report_timeout("waiting for free response IDs");
      end
    end
    for (int i = 0; i < beats; i++) begin
      slot              = next_id + meta_id_t'(i);
      issue_count[slot] = issue_count[slot] + 1;
      exp_addr[slot]    = addr + addr_t'(StrbWidth * i);
      exp_write[slot]   = write;
    end
    // A write changes one word only even with the burst flag set
    if (write) begin
      w = word_of(addr);
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb[b]) begin
          ref_mem[w][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    req.addr          = addr;
    req.write         = write;
    req.data          = data;
    req.strb          = strb;
    req.id            = next_id;
    req.burst.isburst = isburst;
    req.burst.blen    = blen;
    req_valid         = 1'b1;
    next_id           = next_id + meta_id_t'(beats);
    waited            = 0;
    accepted          = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = req_ready;
      waited++;
      if (!accepted && (waited > WaitLimit)) begin
        report_timeout("waiting for the request to be accepted");
      end
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (pending_count() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WaitLimit) begin
        report_timeout("waiting for outstanding responses");
      end
    end
  endtask

  task automatic check_beat(input tcdm_rsp_t beat);
    int w;
    assert (issue_count[beat.id] > rsp_count[beat.id])
      else report_wrong_value($sformatf("response ID %0d is not outstanding", beat.id));
    assert (beat.write == exp_write[beat.id])
      else report_wrong_value($sformatf("response ID %0d has the wrong write flag", beat.id));
    if (beat.write) begin
      assert (beat.data == '0)
        else report_wrong_value($sformatf("write response ID %0d carries data", beat.id));
    end else begin
      w = word_of(exp_addr[beat.id]);
      assert (beat.data == ref_mem[w])
        else report_wrong_value($sformatf("read ID %0d at %h returned %h, expected %h",
                                          beat.id, exp_addr[beat.id], beat.data, ref_mem[w]));
    end
    rsp_count[beat.id] = rsp_count[beat.id] + 1;
  endtask

  // Random back-pressure on the response port
  always @(negedge clk) begin
    logic [31:0] r;
    if (rst_n) begin
      r         = $random(ready_seed);
      rsp_ready = (r[1:0] != 2'b00);
    end else begin
      rsp_ready = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // Nothing comes back before the first request went in
      assert (!rsp_valid || seen_accept)
        else report_wrong_value("response valid before any request was accepted");
      if (stall_q) begin
        assert (rsp_valid && (rsp == stalled_rsp))
          else report_wrong_value("stalled response changed or was withdrawn");
      end
      if (rsp_valid && rsp_ready) begin
        check_beat(rsp);
      end
      if (req_valid && req_ready) begin
        seen_accept = 1'b1;
      end
      stall_q     = rsp_valid && !rsp_ready;
      stalled_rsp = rsp;
    end
  end

  initial begin
    int          waited;
    logic [31:0] r;
    addr_t       addr;
    data_t       data;
    logic        isburst;
    blen_t       blen;
    req       = '0;
    req_valid = 1'b0;
    next_id   = '0;
    seed      = 89862;

    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > WaitLimit) begin
        report_timeout("waiting for reset release");
      end
    end
    @(negedge clk);

    // Known word at every address
    for (int w = 0; w < NumWords; w++) begin
      send_req(addr_t'(w << ByteOffset), 1'b1, fill_word(w), '1, 1'b0, '0);
    end

    // Writes flagged as bursts with random strobes
    for (int k = 0; k < NumBWrites; k++) begin
      r    = $random(seed);
      data = $random(seed);
      addr = addr_t'({r[6:0], 2'b00});
      send_req(addr, 1'b1, data, r[10:7], 1'b1, blen_t'(CutLen));
      bw_addr.push_back(addr);
    end
    wait_drained();

    for (int i = 0; i < NumReads; i++) begin
      r       = $random(seed);
      addr    = addr_t'({r[6:0], 2'b00});
      isburst = r[7];
      blen    = blen_t'(r[10:8] % 5);
      // Every fourth read starts mid-row and runs into the next row
      if (i % 4 == 0) begin
        addr[TileLsb-1:ByteOffset] = BankOffsetBits'(1 + (i / 4) % 3);
        isburst                    = 1'b1;
        blen                       = blen_t'(CutLen);
      end
      send_req(addr, 1'b0, '0, '0, isburst, blen);
    end

    // Whole rows around the flagged writes show the neighbours untouched
    foreach (bw_addr[k]) begin
      addr                       = bw_addr[k];
      addr[TileLsb-1:ByteOffset] = '0;
      send_req(addr, 1'b0, '0, '0, 1'b1, blen_t'(CutLen));
    end
    wait_drained();

    $display("Verification passed");
    $finish;
  end

endmodule

//--- tcdm_burst_cutter.sv
// Burst cutter: splits read bursts that run past a tile row end into two requests
`timescale 1ns/1ps

module tcdm_burst_cutter (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Core side
  input  tcdm_pkg::tcdm_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  // Crossbar side
  output tcdm_pkg::tcdm_req_t req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i
);
  import tcdm_pkg::*;

  cutter_state_e state_d, state_q;

  // Second part of a cut burst
  tcdm_req_t cut_req_d, cut_req_q;

  logic [BankOffsetBits-1:0] row_offset;
  blen_t                     max_blen;
  blen_t                     rest_blen;
  logic                      need_cut;

  // Words left in the row from the start address onwards
  assign row_offset = req_i.addr[TileLsb-1:ByteOffset];
  assign max_blen   = blen_t'(CutLen) - blen_t'(row_offset);
  assign rest_blen  = req_i.burst.blen - max_blen;

  // Only read bursts get cut
  assign need_cut = req_valid_i && req_i.burst.isburst && !req_i.write &&
                    (req_i.burst.blen > max_blen);

  always_comb begin
    state_d     = state_q;
    cut_req_d   = cut_req_q;
    req_o       = req_i;
    req_valid_o = req_valid_i;
    req_ready_o = req_ready_i;

    case (state_q)
      Bypass: begin
        // Write bursts are served as a single word
        if (req_i.write) begin
          req_o.burst = '0;
        end

        if (need_cut) begin
          // First part goes out now while the original stays pending
          req_ready_o      = 1'b0;
          req_o.burst.blen = max_blen;

          cut_req_d.addr          = req_i.addr + (addr_t'(max_blen) << ByteOffset);
          cut_req_d.write         = 1'b0;
          cut_req_d.data          = '0;
          cut_req_d.strb          = '0;
          // The ID may wrap around
          cut_req_d.id            = req_i.id + meta_id_t'(max_blen);
          cut_req_d.burst.isburst = 1'b1;
          cut_req_d.burst.blen    = rest_blen;

          if (req_ready_i) begin
            state_d = BurstCut;
          end
        end
      end

      BurstCut: begin
        // Second part comes from registers and completes the original
        req_o       = cut_req_q;
        req_valid_o = 1'b1;
        req_ready_o = req_ready_i;

        if (req_ready_i) begin
          state_d = Bypass;
        end
      end

      default: begin
        state_d = Bypass;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Bypass;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cut_req_q <= cut_req_d;
  end

  // Every burst leaving the cutter stays inside its row
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_o && req_o.burst.isburst && (req_o.burst.blen > blen_t'(1)))
    |-> ((int'(req_o.addr[TileLsb-1:ByteOffset]) + int'(req_o.burst.blen)) <= CutLen))
    else $error("Burst crosses a tile row end");

endmodule

//--- tcdm_burst_subsys.sv
// TCDM burst subsystem top: burst cutter, tile crossbar, tile banks and response merger
`timescale 1ns/1ps

module tcdm_burst_subsys (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Core request port
  input  tcdm_pkg::tcdm_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  // Response port
  output tcdm_pkg::tcdm_rsp_t rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i
);
  import tcdm_pkg::*;

  tcdm_req_t             cut_req;
  logic                  cut_req_valid;
  logic                  cut_req_ready;

  tcdm_req_t             tile_req;
  logic [NumTiles-1:0]   tile_req_valid;
  logic [NumTiles-1:0]   tile_req_ready;

  tcdm_rsp_t             tile_rsp [NumTiles];
  logic [NumTiles-1:0]   tile_rsp_valid;
  logic [NumTiles-1:0]   tile_rsp_ready;

  tcdm_burst_cutter i_cutter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_o       (cut_req),
    .req_valid_o (cut_req_valid),
    .req_ready_i (cut_req_ready)
  );

  tcdm_tile_xbar i_xbar (
    .req_i            (cut_req),
    .req_valid_i      (cut_req_valid),
    .req_ready_o      (cut_req_ready),
    .tile_req_o       (tile_req),
    .tile_req_valid_o (tile_req_valid),
    .tile_ready_i     (tile_req_ready)
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile
    tcdm_tile_bank i_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (tile_req),
      .req_valid_i (tile_req_valid[t]),
      .req_ready_o (tile_req_ready[t]),
      .rsp_o       (tile_rsp[t]),
      .rsp_valid_o (tile_rsp_valid[t]),
      .rsp_ready_i (tile_rsp_ready[t])
    );
  end

  tcdm_resp_arbiter i_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tile_rsp_i       (tile_rsp),
    .tile_rsp_valid_i (tile_rsp_valid),
    .tile_rsp_ready_o (tile_rsp_ready),
    .rsp_o            (rsp_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i)
  );

endmodule

//--- tcdm_pkg.sv
// TCDM burst subsystem package: address map, widths, request/response payloads, FSM states
package tcdm_pkg;

  // Address map
  localparam int unsigned AddrWidth      = 16;
  localparam int unsigned ByteOffset     = 2;
  localparam int unsigned CutLen         = 4;
  localparam int unsigned BankOffsetBits = $clog2(CutLen);
  localparam int unsigned NumTiles       = 2;
  localparam int unsigned TileIdBits     = 1;
  localparam int unsigned TileDepth      = 64;
  localparam int unsigned BLenWidth      = 3;

  // Payload widths
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned MetaIdWidth    = 4;
  localparam int unsigned TileAddrWidth  = $clog2(TileDepth);

  // Bit positions derived from the map
  localparam int unsigned TileLsb        = ByteOffset + BankOffsetBits;
  localparam int unsigned RowLsb         = TileLsb + TileIdBits;
  localparam int unsigned RowBits        = TileAddrWidth - BankOffsetBits;

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [StrbWidth-1:0]     strb_t;
  typedef logic [MetaIdWidth-1:0]   meta_id_t;
  typedef logic [BLenWidth-1:0]     blen_t;
  typedef logic [TileIdBits-1:0]    tile_id_t;
  typedef logic [TileAddrWidth-1:0] tile_addr_t;

  // Burst descriptor, blen of 0 or 1 is a single word
  typedef struct packed {
    logic  isburst;
    blen_t blen;
  } tcdm_breq_t;

  typedef struct packed {
    addr_t      addr;
    logic       write;
    data_t      data;
    strb_t      strb;
    meta_id_t   id;
    tcdm_breq_t burst;
  } tcdm_req_t;

  // One response beat, writes come back with zero data
  typedef struct packed {
    data_t    data;
    meta_id_t id;
    logic     write;
  } tcdm_rsp_t;

  typedef enum logic {
    Bypass,
    BurstCut
  } cutter_state_e;

  typedef enum logic {
    BankIdle,
    BankBurst
  } bank_state_e;

endpackage

//--- tcdm_resp_arbiter.sv
// Response arbiter: round-robin merge of the tile response streams with a locked grant
`timescale 1ns/1ps

module tcdm_resp_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Tile responses
  input  tcdm_pkg::tcdm_rsp_t                 tile_rsp_i [tcdm_pkg::NumTiles],
  input  logic [tcdm_pkg::NumTiles-1:0]       tile_rsp_valid_i,
  output logic [tcdm_pkg::NumTiles-1:0]       tile_rsp_ready_o,
  // Merged response
  output tcdm_pkg::tcdm_rsp_t                 rsp_o,
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i
);
  import tcdm_pkg::*;

  tile_id_t rr_q;
  tile_id_t grant_q;
  logic     lock_q;
  tile_id_t sel;
  tile_id_t cand;
  logic     found;

  // First valid tile from the pointer on, or the locked one
  always_comb begin
    sel   = rr_q;
    cand  = rr_q;
    found = 1'b0;
    for (int i = 0; i < NumTiles; i++) begin
      cand = tile_id_t'((int'(rr_q) + i) % NumTiles);
      if (!found && tile_rsp_valid_i[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
    if (lock_q) begin
      sel = grant_q;
    end
  end

  assign rsp_o       = tile_rsp_i[sel];
  assign rsp_valid_o = tile_rsp_valid_i[sel];

  always_comb begin
    tile_rsp_ready_o      = '0;
    tile_rsp_ready_o[sel] = rsp_ready_i && tile_rsp_valid_i[sel];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q    <= '0;
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else if (rsp_valid_o) begin
      // Hold the grant while stalled, move past it after the transfer
      grant_q <= sel;
      lock_q  <= !rsp_ready_i;
      if (rsp_ready_i) begin
        rr_q <= tile_id_t'((int'(sel) + 1) % NumTiles);
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(tile_rsp_ready_o))
    else $error("More than one tile response accepted");

endmodule

//--- tcdm_tile_bank.sv
// Tile bank: word memory serving writes, single reads and beat-by-beat burst reads
`timescale 1ns/1ps

module tcdm_tile_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Request from the crossbar
  input  tcdm_pkg::tcdm_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  // Response to the arbiter
  output tcdm_pkg::tcdm_rsp_t rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i
);
  import tcdm_pkg::*;

  data_t       mem_q [TileDepth];

  bank_state_e state_d, state_q;
  tcdm_rsp_t   rsp_d, rsp_q;
  logic        rsp_valid_d, rsp_valid_q;
  tile_addr_t  beat_idx_d, beat_idx_q;
  blen_t       beats_left_d, beats_left_q;

  tile_addr_t  req_idx;
  logic        req_hs;
  logic        req_is_burst;

  // Word index is the row above the tile bit joined with the row offset
  assign req_idx = {req_i.addr[RowLsb +: RowBits], req_i.addr[TileLsb-1:ByteOffset]};

  // Idle and the response register free or draining this cycle
  assign req_ready_o  = (state_q == BankIdle) && (!rsp_valid_q || rsp_ready_i);
  assign req_hs       = req_valid_i && req_ready_o;
  assign req_is_burst = req_i.burst.isburst && (req_i.burst.blen > blen_t'(1));

  always_comb begin
    state_d      = state_q;
    rsp_d        = rsp_q;
    rsp_valid_d  = rsp_valid_q;
    beat_idx_d   = beat_idx_q;
    beats_left_d = beats_left_q;

    if (rsp_valid_q && rsp_ready_i) begin
      rsp_valid_d = 1'b0;
    end

    case (state_q)
      BankIdle: begin
        if (req_hs) begin
          rsp_valid_d = 1'b1;
          rsp_d.id    = req_i.id;
          rsp_d.write = req_i.write;
          if (req_i.write) begin
            rsp_d.data = '0;
          end else begin
            rsp_d.data = mem_q[req_idx];
            if (req_is_burst) begin
              state_d      = BankBurst;
              beat_idx_d   = req_idx + tile_addr_t'(1);
              beats_left_d = req_i.burst.blen - blen_t'(1);
            end
          end
        end
      end

      BankBurst: begin
        // Next beat loads as the current one leaves
        if (rsp_ready_i) begin
          rsp_valid_d  = 1'b1;
          rsp_d.data   = mem_q[beat_idx_q];
          rsp_d.id     = rsp_q.id + meta_id_t'(1);
          beat_idx_d   = beat_idx_q + tile_addr_t'(1);
          beats_left_d = beats_left_q - blen_t'(1);
          if (beats_left_q == blen_t'(1)) begin
            state_d = BankIdle;
          end
        end
      end

      default: begin
        state_d = BankIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (req_hs && req_i.write) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (req_i.strb[b]) begin
          mem_q[req_idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= BankIdle;
      rsp_valid_q  <= 1'b0;
      beats_left_q <= '0;
    end else begin
      state_q      <= state_d;
      rsp_valid_q  <= rsp_valid_d;
      beats_left_q <= beats_left_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q      <= rsp_d;
    beat_idx_q <= beat_idx_d;
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  // A stalled beat is held unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else $error("Stalled tile response changed");

endmodule

//--- tcdm_tile_xbar.sv
// Tile crossbar: steers each request to the tile picked by its address bits
`timescale 1ns/1ps

module tcdm_tile_xbar (
  // Request from the cutter
  input  tcdm_pkg::tcdm_req_t                 req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  // Requests to the tiles
  output tcdm_pkg::tcdm_req_t                 tile_req_o,
  output logic [tcdm_pkg::NumTiles-1:0]       tile_req_valid_o,
  input  logic [tcdm_pkg::NumTiles-1:0]       tile_ready_i
);
  import tcdm_pkg::*;

  tile_id_t tile_sel;

  // Tile index sits just above the row offset
  assign tile_sel = req_i.addr[TileLsb +: TileIdBits];

  // Payload goes to every tile, only one sees valid
  assign tile_req_o = req_i;

  always_comb begin
    tile_req_valid_o = '0;
    for (int t = 0; t < NumTiles; t++) begin
      if (tile_sel == tile_id_t'(t)) begin
        tile_req_valid_o[t] = req_valid_i;
      end
    end
  end

  // Back-pressure comes from the addressed tile only
  assign req_ready_o = tile_ready_i[tile_sel];

  // Valid reaches at most one tile and is never lost on the way
  always_comb begin
    assert final ($onehot0(tile_req_valid_o) && ((|tile_req_valid_o) == req_valid_i))
      else $error("Tile valids not one-hot");
  end

endmodule

//--- vlog.f
tcdm_pkg.sv
tcdm_burst_cutter.sv
tcdm_tile_xbar.sv
tcdm_tile_bank.sv
tcdm_resp_arbiter.sv
tcdm_burst_subsys.sv
tb_clk_gen.sv
tb_tcdm_burst_subsys.sv
